// File: design/dcache_defines.svh
// Geometry of the 2-way data cache, shared by packages and RTL
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

//------------------------------
// Word and address widths
//------------------------------
`define DC_XLEN 32     // Data word
`define DC_PLEN 32     // Physical address

//------------------------------
// Cache organisation
//------------------------------
`define DC_WAYS 2

// 16 sets of 16-byte lines
`define DC_SETS 16
`define DC_BEATS 4     // Words per line, also bus beats per burst

`endif

// File: design/dcache_pkg.sv
// Data cache types for geometry, CPU requests and the control FSM
`default_nettype none

`include "dcache_defines.svh"

package dcache_pkg;

  //------------------------------
  // Widths with a meaning
  //------------------------------
  typedef logic [`DC_XLEN-1:0]   word_t;
  typedef logic [`DC_PLEN-1:0]   addr_t;
  typedef logic [`DC_XLEN/8-1:0] be_t;

  // Address split is tag | index | word offset | byte offset
  typedef logic [`DC_PLEN-$clog2(`DC_SETS)-$clog2(`DC_BEATS*`DC_XLEN/8)-1:0] tag_t;
  typedef logic [$clog2(`DC_SETS)-1:0]    idx_t;
  typedef logic [$clog2(`DC_BEATS)-1:0]   offs_t;
  typedef logic [`DC_BEATS*`DC_XLEN-1:0]  line_t;
  typedef logic [$clog2(`DC_WAYS)-1:0]    way_t;
  typedef logic [`DC_WAYS-1:0]            ways_t;  // One bit per way

  // CPU request, held stable until acknowledged
  typedef struct packed {
    addr_t addr;
    logic  we;    // 1 = store
    be_t   be;
    word_t wdata;
  } cpu_req_t;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,  // Compare tags
    DC_EVICT,   // Pick victim, write back if dirty
    DC_FILL,    // Line fill from the bus
    DC_DONE
  } dc_state_e;

endpackage

`default_nettype wire

// File: design/biu_pkg.sv
// Bus interface types for burst commands and beat counting
`default_nettype none

`include "dcache_defines.svh"

package biu_pkg;

  //------------------------------
  // Burst command
  //------------------------------

  // Line-aligned start address plus direction
  typedef struct packed {
    logic [`DC_PLEN-1:0] addr;
    logic                we;    // 1 = write-back, 0 = fill
  } biu_cmd_t;

  // Counts the beats of one burst
  typedef logic [$clog2(`DC_BEATS)-1:0] beat_t;

endpackage

`default_nettype wire

// File: design/dcache_tag_array.sv
// Tag array holding tag, valid and dirty bits per way with per-way hit compare
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_tag_array (
  input  logic               clk_i,
  input  logic               rst_ni,

  input  dcache_pkg::idx_t   idx_i,
  input  dcache_pkg::tag_t   tag_i,
  input  logic               rd_en_i,
  input  dcache_pkg::way_t   victim_way_i,

  input  dcache_pkg::ways_t  we_i,
  input  logic               dirty_i,

  output dcache_pkg::ways_t  ways_hit_o,
  output logic               victim_valid_o,
  output logic               victim_dirty_o,
  output dcache_pkg::tag_t   victim_tag_o
);
  import dcache_pkg::*;

  tag_t  tag_q [`DC_SETS][`DC_WAYS];
  ways_t valid_q [`DC_SETS];
  ways_t dirty_q [`DC_SETS];

  // Registered read port
  tag_t  rd_tag_q [`DC_WAYS];
  ways_t rd_valid_q;
  ways_t rd_dirty_q;

  //------------------------------
  // Tag storage
  //------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (rd_en_i) rd_tag_q[w] <= tag_q[idx_i][w];
      if (we_i[w]) tag_q[idx_i][w] <= tag_i;
    end
  end

  // Status bits come up cleared
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '{default: '0};
      dirty_q    <= '{default: '0};
      rd_valid_q <= '0;
      rd_dirty_q <= '0;
    end else begin
      if (rd_en_i) begin
        rd_valid_q <= valid_q[idx_i];
        rd_dirty_q <= dirty_q[idx_i];
      end
      for (int w = 0; w < `DC_WAYS; w++) begin
        if (we_i[w]) begin
          valid_q[idx_i][w] <= 1'b1;
          dirty_q[idx_i][w] <= dirty_i;
        end
      end
    end
  end

  //------------------------------
  // Hit compare
  //------------------------------
  always_comb begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      ways_hit_o[w] = rd_valid_q[w] && (rd_tag_q[w] == tag_i);
    end
  end

  assign victim_valid_o = rd_valid_q[victim_way_i];
  assign victim_dirty_o = rd_dirty_q[victim_way_i];
  assign victim_tag_o   = rd_tag_q[victim_way_i];  // Rebuilds write-back address

endmodule

`default_nettype wire

// File: design/dcache_data_array.sv
// Data array storing the lines of each way with word writes and line fills
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_data_array (
  input  logic               clk_i,

  input  dcache_pkg::idx_t   idx_i,
  input  logic               rd_en_i,
  input  dcache_pkg::way_t   rd_way_i,

  input  dcache_pkg::ways_t  we_i,
  input  dcache_pkg::be_t    be_i,
  input  dcache_pkg::offs_t  offs_i,
  input  dcache_pkg::word_t  wdata_i,

  input  logic               fill_i,       // Whole line instead of one word
  input  dcache_pkg::line_t  fill_line_i,

  output dcache_pkg::line_t  line_o
);
  import dcache_pkg::*;

  line_t mem_q [`DC_WAYS][`DC_SETS];
  line_t rd_q [`DC_WAYS];  // All ways read, way picked afterwards

  //------------------------------
  // Read and write port
  //------------------------------
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (rd_en_i) rd_q[w] <= mem_q[w][idx_i];

      if (we_i[w]) begin
        if (fill_i) begin
          mem_q[w][idx_i] <= fill_line_i;
        end else begin
          // Byte lanes of the addressed word
          for (int b = 0; b < `DC_XLEN/8; b++) begin
            if (be_i[b]) begin
              mem_q[w][idx_i][int'(offs_i)*`DC_XLEN + b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
          end
        end
      end
    end
  end

  // Way select arrives late, after the hit compare
  assign line_o = rd_q[rd_way_i];

endmodule

`default_nettype wire

// File: design/dcache_biu_ctrl.sv
// Bus burst sequencer moving one cache line per command, for fills and write-backs
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_biu_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,

  // From cache control
  input  logic                start_i,
  input  biu_pkg::biu_cmd_t   cmd_i,
  input  dcache_pkg::line_t   evict_line_i,
  output logic                done_o,
  output dcache_pkg::line_t   fill_line_o,

  // Bus
  output logic                biu_stb_o,
  input  logic                biu_stb_ack_i,
  output biu_pkg::biu_cmd_t   biu_cmd_o,
  input  logic                biu_ack_i,
  output dcache_pkg::word_t   biu_d_o,
  input  dcache_pkg::word_t   biu_q_i
);
  import dcache_pkg::*;
  import biu_pkg::*;

  logic     stb_q;     // Command offered
  logic     act_q;     // Beats running
  logic     done_q;
  beat_t    beat_q;
  biu_cmd_t cmd_q;
  line_t    buf_q;     // Write-back data out, fill data in

  //------------------------------
  // Handshake sequencing
  //------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stb_q  <= 1'b0;
      act_q  <= 1'b0;
      done_q <= 1'b0;
      beat_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        stb_q  <= 1'b1;
        beat_q <= '0;
      end else if (stb_q && biu_stb_ack_i) begin
        stb_q <= 1'b0;
        act_q <= 1'b1;
      end else if (act_q && biu_ack_i) begin
        beat_q <= beat_q + 1'b1;
        if (beat_q == beat_t'(`DC_BEATS-1)) begin  // Last beat
          act_q  <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  // Lowest word always faces the bus, read words enter at the top
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      cmd_q <= cmd_i;
      buf_q <= evict_line_i;
    end else if (act_q && biu_ack_i) begin
      buf_q <= {biu_q_i, buf_q[`DC_BEATS*`DC_XLEN-1:`DC_XLEN]};
    end
  end

  assign biu_stb_o   = stb_q;
  assign biu_cmd_o   = cmd_q;
  assign biu_d_o     = buf_q[`DC_XLEN-1:0];
  assign done_o      = done_q;
  assign fill_line_o = buf_q;  // Complete when done_o is high

  //------------------------------
  // Checks
  //------------------------------

  // A beat is only legal once the command was taken
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_ack_i |-> act_q)
    else $error("biu_ack_i without an accepted command");

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
// Control FSM of the data cache handling lookup, victim choice, write-back and fill
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module dcache_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // CPU
  input  logic                 req_i,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 ack_o,
  output dcache_pkg::word_t    rdata_o,

  // Array addressing
  output dcache_pkg::idx_t     idx_o,
  output dcache_pkg::tag_t     tag_o,
  output logic                 rd_en_o,
  output dcache_pkg::way_t     way_o,

  // Tag array
  input  dcache_pkg::ways_t    ways_hit_i,
  input  logic                 victim_valid_i,
  input  logic                 victim_dirty_i,
  input  dcache_pkg::tag_t     victim_tag_i,
  output dcache_pkg::ways_t    tag_we_o,
  output logic                 tag_dirty_o,

  // Data array
  input  dcache_pkg::line_t    data_line_i,
  output dcache_pkg::ways_t    data_we_o,
  output dcache_pkg::be_t      data_be_o,
  output dcache_pkg::offs_t    data_offs_o,
  output dcache_pkg::word_t    data_wdata_o,
  output logic                 fill_o,
  output dcache_pkg::line_t    fill_line_o,

  // Burst unit
  output logic                 start_o,
  output biu_pkg::biu_cmd_t    cmd_o,
  output dcache_pkg::line_t    evict_line_o,
  input  logic                 done_i,
  input  dcache_pkg::line_t    fill_line_i
);
  import dcache_pkg::*;
  import biu_pkg::*;

  localparam int unsigned OFFS_LSB = $clog2(`DC_XLEN/8);
  localparam int unsigned IDX_LSB  = OFFS_LSB + $clog2(`DC_BEATS);
  localparam int unsigned TAG_LSB  = IDX_LSB + $clog2(`DC_SETS);

  dc_state_e state_q, state_d;
  cpu_req_t  req_q;
  word_t     rdata_q;
  way_t      way_q, way_d, hit_way;
  logic      probe_q, probe_d;  // Way 1 validity still unknown
  logic      busy_q, busy_d;    // Burst outstanding
  logic [6:0] lfsr_q;
  idx_t      req_idx;
  offs_t     req_offs;

  assign req_idx  = req_q.addr[TAG_LSB-1:IDX_LSB];
  assign req_offs = req_q.addr[IDX_LSB-1:OFFS_LSB];

  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `DC_WAYS; w++) begin
      if (ways_hit_i[w]) hit_way = way_t'(w);
    end
  end

  assign idx_o        = (state_q == DC_IDLE) ? cpu_req_i.addr[TAG_LSB-1:IDX_LSB] : req_idx;
  assign tag_o        = req_q.addr[`DC_PLEN-1:TAG_LSB];
  assign way_o        = (state_q == DC_LOOKUP) ? hit_way : way_q;
  assign data_be_o    = req_q.be;
  assign data_offs_o  = req_offs;
  assign data_wdata_o = req_q.wdata;
  assign fill_line_o  = fill_line_i;
  assign evict_line_o = data_line_i;  // Line of the way on way_o
  assign ack_o        = (state_q == DC_DONE);
  assign rdata_o      = rdata_q;

  //------------------------------
  // Next state and array control
  //------------------------------
  always_comb begin
    state_d     = state_q;
    way_d       = way_q;
    probe_d     = probe_q;
    rd_en_o     = 1'b0;
    tag_we_o    = '0;
    tag_dirty_o = 1'b0;
    data_we_o   = '0;
    fill_o      = 1'b0;
    start_o     = 1'b0;
    cmd_o.addr  = {req_q.addr[`DC_PLEN-1:IDX_LSB], {IDX_LSB{1'b0}}};  // Fill by default
    cmd_o.we    = 1'b0;

    case (state_q)
      DC_IDLE: if (req_i) begin
        rd_en_o = 1'b1;
        way_d   = '0;
        probe_d = 1'b1;
        state_d = DC_LOOKUP;
      end
      DC_LOOKUP: begin
        if (|ways_hit_i) begin
          if (req_q.we) begin
            tag_we_o    = ways_hit_i;
            tag_dirty_o = 1'b1;
            data_we_o   = ways_hit_i;
          end
          state_d = DC_DONE;
        end else if (!victim_valid_i) begin  // Way 0 free
          start_o = 1'b1;
          state_d = DC_FILL;
        end else begin
          way_d   = way_t'(1);
          state_d = DC_EVICT;
        end
      end
      DC_EVICT: begin
        if (busy_q) begin
          if (done_i) begin     // Write-back finished, fill next
            start_o = 1'b1;
            state_d = DC_FILL;
          end
        end else if (probe_q) begin
          if (!victim_valid_i) begin
            start_o = 1'b1;
            state_d = DC_FILL;
          end else begin
            way_d   = way_t'(lfsr_q[0]);  // Both valid
            probe_d = 1'b0;
          end
        end else begin
          start_o = 1'b1;
          if (victim_dirty_i) begin
            cmd_o.addr = {victim_tag_i, req_idx, {IDX_LSB{1'b0}}};
            cmd_o.we   = 1'b1;
          end else begin
            state_d = DC_FILL;
          end
        end
      end
      DC_FILL: if (done_i) begin
        tag_we_o  = ways_t'(1) << way_q;
        data_we_o = ways_t'(1) << way_q;
        fill_o    = 1'b1;
        state_d   = DC_IDLE;  // Held request replays as a hit
      end
      DC_DONE: state_d = DC_IDLE;
      default: state_d = DC_IDLE;
    endcase

    busy_d = busy_q;
    if (done_i)  busy_d = 1'b0;
    if (start_o) busy_d = 1'b1;
  end

  //------------------------------
  // Registers
  //------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DC_IDLE;
      way_q   <= '0;
      probe_q <= 1'b0;
      busy_q  <= 1'b0;
      lfsr_q  <= '0;
    end else begin
      state_q <= state_d;
      way_q   <= way_d;
      probe_q <= probe_d;
      busy_q  <= busy_d;
      if (state_q != DC_FILL) lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == DC_IDLE && req_i) req_q <= cpu_req_i;
    if (state_q == DC_LOOKUP) rdata_q <= data_line_i[int'(req_offs)*`DC_XLEN +: `DC_XLEN];
  end

  // Burst unit takes one command at a time
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_o |-> (!busy_q || done_i))
    else $error("start_o while a burst is outstanding");

  // A line lives in one way only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(ways_hit_i))
    else $error("ways_hit_i has more than one bit set");

endmodule

`default_nettype wire

// File: design/dcache_top.sv
// Top level of the 2-way write-back data cache joining control, arrays and burst unit
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 req_i,
  input  dcache_pkg::cpu_req_t cpu_req_i,
  output logic                 ack_o,
  output dcache_pkg::word_t    rdata_o,

  output logic                 biu_stb_o,
  input  logic                 biu_stb_ack_i,
  input  logic                 biu_ack_i,
  output biu_pkg::biu_cmd_t    biu_cmd_o,
  output dcache_pkg::word_t    biu_d_o,
  input  dcache_pkg::word_t    biu_q_i
);

  dcache_pkg::idx_t  idx;
  dcache_pkg::tag_t  tag;
  logic              rd_en;
  dcache_pkg::way_t  way;
  dcache_pkg::ways_t ways_hit, tag_we, data_we;
  logic              victim_valid, victim_dirty, tag_dirty;
  dcache_pkg::tag_t  victim_tag;
  dcache_pkg::line_t data_line, wr_line, biu_line, evict_line;
  dcache_pkg::be_t   data_be;
  dcache_pkg::offs_t data_offs;
  dcache_pkg::word_t data_wdata;
  logic              fill, biu_start, biu_done;
  biu_pkg::biu_cmd_t biu_cmd;

  dcache_ctrl u_ctrl (
    .clk_i, .rst_ni, .req_i, .cpu_req_i, .ack_o, .rdata_o,
    .idx_o          (idx),          .tag_o          (tag),
    .rd_en_o        (rd_en),        .way_o          (way),
    .ways_hit_i     (ways_hit),     .victim_valid_i (victim_valid),
    .victim_dirty_i (victim_dirty), .victim_tag_i   (victim_tag),
    .tag_we_o       (tag_we),       .tag_dirty_o    (tag_dirty),
    .data_line_i    (data_line),    .data_we_o      (data_we),
    .data_be_o      (data_be),      .data_offs_o    (data_offs),
    .data_wdata_o   (data_wdata),   .fill_o         (fill),
    .fill_line_o    (wr_line),      .start_o        (biu_start),
    .cmd_o          (biu_cmd),      .evict_line_o   (evict_line),
    .done_i         (biu_done),     .fill_line_i    (biu_line)
  );

  dcache_tag_array u_tags (
    .clk_i, .rst_ni,
    .idx_i          (idx),          .tag_i          (tag),
    .rd_en_i        (rd_en),        .victim_way_i   (way),
    .we_i           (tag_we),       .dirty_i        (tag_dirty),
    .ways_hit_o     (ways_hit),     .victim_valid_o (victim_valid),
    .victim_dirty_o (victim_dirty), .victim_tag_o   (victim_tag)
  );

  dcache_data_array u_data (
    .clk_i,
    .idx_i   (idx),        .rd_en_i     (rd_en),   .rd_way_i (way),
    .we_i    (data_we),    .be_i        (data_be), .offs_i   (data_offs),
    .wdata_i (data_wdata), .fill_i      (fill),    .fill_line_i (wr_line),
    .line_o  (data_line)
  );

  dcache_biu_ctrl u_biu (
    .clk_i, .rst_ni,
    .start_i     (biu_start), .cmd_i       (biu_cmd), .evict_line_i (evict_line),
    .done_o      (biu_done),  .fill_line_o (biu_line),
    .biu_stb_o, .biu_stb_ack_i, .biu_cmd_o, .biu_ack_i, .biu_d_o, .biu_q_i
  );

endmodule

`default_nettype wire

// File: sim/tb_mem_model.sv
// Behavioral bus memory answering line bursts with random acknowledge delays
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tb_mem_model (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              stb_i,
  output logic              stb_ack_o,
  input  biu_pkg::biu_cmd_t cmd_i,
  output logic              ack_o,
  input  dcache_pkg::word_t d_i,
  output dcache_pkg::word_t q_o
);
  import dcache_pkg::*;
  import biu_pkg::*;

  localparam word_t FILL_KEY = 32'hCAFE0000;

  word_t       mem [logic [29:0]];  // Only written words are stored
  logic [31:0] rng;

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Unwritten words follow their word address
  function automatic word_t read_word(input addr_t addr);
    if (mem.exists(addr[31:2])) return mem[addr[31:2]];
    return word_t'(addr[31:2]) ^ FILL_KEY;
  endfunction

  // Stall of 0 to 3 cycles
  task automatic random_pause();
    int cycles;
    rng    = next_rand(rng);
    cycles = int'(rng[1:0]);
    repeat (cycles) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  //------------------------------
  // Burst responder
  //------------------------------
  task automatic serve_burst();
    biu_cmd_t cmd;
    addr_t    addr;
    int       beat;
    cmd = cmd_i;
    random_pause();
    stb_ack_o = 1'b1;
    @(posedge clk_i);
    #1;
    stb_ack_o = 1'b0;
    for (beat = 0; beat < `DC_BEATS; beat++) begin
      random_pause();
      addr = cmd.addr + addr_t'(beat << 2);
      if (cmd.we) mem[addr[31:2]] = d_i;  // Current beat is stable here
      else q_o = read_word(addr);
      ack_o = 1'b1;
      @(posedge clk_i);
      #1;
      ack_o = 1'b0;
    end
  endtask

  initial begin
    stb_ack_o = 1'b0;
    ack_o     = 1'b0;
    q_o       = '0;
    rng       = 32'h9789;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_ni && stb_i) serve_burst();
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_dcache.sv
// Testbench for the data cache replaying file operations and checking read data
`timescale 1ns/1ps
`default_nettype none

`include "dcache_defines.svh"

module tb_dcache;
  import dcache_pkg::*;
  import biu_pkg::*;

  localparam int ACK_TIMEOUT = 200;  // Cycles per request
  localparam int HIT_CYCLES  = 2;

  logic     clk;
  logic     rst_n;
  logic     req;
  cpu_req_t cpu_req;
  logic     ack;
  word_t    rdata;
  logic     biu_stb, biu_stb_ack, biu_ack;
  biu_cmd_t biu_cmd;
  word_t    biu_d, biu_q;

  // Stimulus file fields
  int          fd;
  int          c;
  int          fields;
  int          ops;
  logic [31:0] f_addr, f_be, f_wdata, f_exp;
  logic [27:0] prev_line;
  logic        have_prev;

  int   bursts;    // Bus monitor
  int   beat_cnt;
  logic stb_prev;  // Strobe at the previous falling edge

  dcache_top u_dcache_top (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_i         (req),
    .cpu_req_i     (cpu_req),
    .ack_o         (ack),
    .rdata_o       (rdata),
    .biu_stb_o     (biu_stb),
    .biu_stb_ack_i (biu_stb_ack),
    .biu_ack_i     (biu_ack),
    .biu_cmd_o     (biu_cmd),
    .biu_d_o       (biu_d),
    .biu_q_i       (biu_q)
  );

  tb_mem_model u_mem (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .stb_i     (biu_stb),
    .stb_ack_o (biu_stb_ack),
    .cmd_i     (biu_cmd),
    .ack_o     (biu_ack),
    .d_i       (biu_d),
    .q_o       (biu_q)
  );

  always #2 clk = ~clk;

  //------------------------------
  // Checking helpers
  //------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] time %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("** FAIL **");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "Run aborted");
  endtask

  // One request, held until acknowledged
  task automatic run_op(input logic is_write, input addr_t addr, input be_t be,
                        input word_t wdata, input word_t exp_rdata, input logic expect_hit);
    int cycles;
    cpu_req.addr  = addr;
    cpu_req.we    = is_write;
    cpu_req.be    = be;
    cpu_req.wdata = wdata;
    req           = 1'b1;
    cycles        = 0;
    while (!ack && cycles < ACK_TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!ack) abort_run($sformatf("No ack_o within %0d cycles for address %h",
                                  ACK_TIMEOUT, addr));
    if (expect_hit) check_value("ack_o latency", 32'(cycles), 32'(HIT_CYCLES));
    if (!is_write) check_value("rdata_o", rdata, exp_rdata);
    req = 1'b0;
    @(posedge clk);
    #1;
  endtask

  //------------------------------
  // Bus monitor
  //------------------------------
  // A new command from the cache must follow a complete burst
  always @(negedge clk) begin
    if (rst_n) begin
      if (biu_stb && !stb_prev) begin
        if (bursts > 0) check_value("beats per burst", 32'(beat_cnt), 32'(`DC_BEATS));
        bursts++;
        beat_cnt = 0;
      end
      if (biu_ack) beat_cnt++;
    end
    stb_prev = biu_stb;
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req       = 1'b0;
    cpu_req   = '0;
    ops       = 0;
    bursts    = 0;
    beat_cnt  = 0;
    stb_prev  = 1'b0;
    have_prev = 1'b0;
    prev_line = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    fd = $fopen("sim/dcache_stim.txt", "r");
    if (fd == 0) abort_run("Cannot open the stimulus file sim/dcache_stim.txt");

    c = $fgetc(fd);
    while (c != -1) begin
      if (c == "#") begin
        while (c != "\n" && c != -1) c = $fgetc(fd);
      end else if (c == "R" || c == "W") begin
        fields = $fscanf(fd, "%h %h %h %h", f_addr, f_be, f_wdata, f_exp);
        if (fields != 4) abort_run("Malformed line in the stimulus file");
        // Line touched by the previous request must still be present
        run_op(c == "W", f_addr, f_be[3:0], f_wdata, f_exp,
               have_prev && (f_addr[31:4] == prev_line));
        prev_line = f_addr[31:4];
        have_prev = 1'b1;
        ops++;
      end
      c = $fgetc(fd);
    end
    $fclose(fd);

    if (ops == 0) abort_run("The stimulus file holds no operations");
    if (bursts == 0) abort_run("No bus burst was seen");
    check_value("beats in last burst", 32'(beat_cnt), 32'(`DC_BEATS));
    $display("%0d operations and %0d bursts checked", ops, bursts);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+design
design/dcache_pkg.sv
design/biu_pkg.sv
design/dcache_tag_array.sv
design/dcache_data_array.sv
design/dcache_biu_ctrl.sv
design/dcache_ctrl.sv
design/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the data cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dcache -f files.f -o Vtb_dcache

output="$(./obj_dir/Vtb_dcache 2>&1 || true)"
echo "$output"

if grep -qF '** PASS **' <<< "$output"; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// File: sim/dcache_stim.txt
# op address be wdata expected_read_data (expected is ignored for W)
# Words never written read back as (address >> 2) ^ cafe0000
R 00000040 f 00000000 cafe0010
R 00000044 f 00000000 cafe0011
W 00000048 3 12345678 00000000
R 00000048 f 00000000 cafe5678
W 00001010 f deadbeef 00000000
W 00001014 c a5a50000 00000000
R 00002010 f 00000000 cafe0804
R 00003010 f 00000000 cafe0c04
R 00004014 f 00000000 cafe1005
R 0000501c f 00000000 cafe1407
R 00001010 f 00000000 deadbeef
R 00001014 f 00000000 a5a50405
R 00001018 f 00000000 cafe0406
R 00000044 f 00000000 cafe0011
W 000000f0 1 000000ab 00000000
R 000000f0 f 00000000 cafe00ab
R 000010f0 f 00000000 cafe043c
R 000020f0 f 00000000 cafe083c
R 000030fc f 00000000 cafe0c3f
R 000000f0 f 00000000 cafe00ab
